// ==== hdl/bus_port.sv ====
`default_nettype none

module bus_port import dcache_pkg::*; #(
    parameter int LINE_BYTES = DEF_LINE_BYTES,
    localparam int OFF_W     = $clog2(LINE_BYTES),
    localparam int LINE_W    = LINE_BYTES * 8
) (
    input  wire               clk,
    input  wire               clr_n,
    input  wire addr_t        line_addr,
    input  wire               start_read,
    input  wire               start_write,
    input  wire [LINE_W-1:0]  wline,
    output bus_req_t          bus_req,
    output logic [LINE_W-1:0] bus_wdata,
    output logic              bus_valid,
    input  wire               bus_ready,
    input  wire [LINE_W-1:0]  bus_rdata,
    input  wire               bus_rvalid,
    output logic [LINE_W-1:0] fill_line,
    output logic              fill_done,
    output logic              write_done
);

    logic rd_wait;

    // a write is finished once the bus accepts it
    assign write_done = bus_valid && bus_ready && bus_req.we;

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            bus_valid <= 1'b0;
            rd_wait   <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= rd_wait && bus_rvalid;
            if (start_read || start_write) begin
                bus_valid <= 1'b1;
            end else if (bus_ready) begin
                bus_valid <= 1'b0;
            end
            if (start_read) begin
                rd_wait <= 1'b1;
            end else if (bus_rvalid) begin
                rd_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_read || start_write) begin
            bus_req.addr <= {line_addr[$bits(addr_t)-1:OFF_W], {OFF_W{1'b0}}};
            bus_req.we   <= start_write;
        end
        if (start_write) begin
            bus_wdata <= wline;
        end
        if (rd_wait && bus_rvalid) begin
            fill_line <= bus_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_array.sv ====
`default_nettype none

module dcache_array import dcache_pkg::*; #(
    parameter int SETS       = DEF_SETS,
    parameter int LINE_BYTES = DEF_LINE_BYTES,
    localparam int SET_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_BYTES),
    localparam int TAG_W     = $bits(addr_t) - SET_W - OFF_W,
    localparam int LINE_W    = LINE_BYTES * 8
) (
    input  wire               clk,
    input  wire               clr_n,
    input  wire [TAG_W-1:0]   tag,
    input  wire [SET_W-1:0]   set,
    input  wire [OFF_W-1:0]   offset,
    input  wire mem_size_t    size,
    input  wire dword_t       wdata,
    input  wire way_t         victim,
    input  wire               fill_en,
    input  wire               store_en,
    input  wire [LINE_W-1:0]  fill_line,
    output logic              hit,
    output way_t              hit_way,
    output dword_t            rdata,
    output logic [LINE_W-1:0] line_out
);

    logic [TAG_W-1:0]  tag_q   [SETS][4];
    logic              valid_q [SETS][4];
    logic [LINE_W-1:0] data_q  [SETS][4];

    logic [LINE_W-1:0] hit_line;
    logic [OFF_W+2:0]  shift;
    dword_t            word;
    dword_t            size_mask;
    logic [LINE_W-1:0] lane_mask;
    logic [LINE_W-1:0] lane_data;

    // four-way tag compare
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < 4; w++) begin
            if (valid_q[set][w] && tag_q[set][w] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line = data_q[set][hit_way];
    assign shift    = {offset, 3'b000};
    assign word     = dword_t'(hit_line >> shift);

    // load data, accesses are naturally aligned
    always_comb begin
        case (size)
            SZ_B:    rdata = {{56{word[7]}}, word[7:0]};
            SZ_H:    rdata = {{48{word[15]}}, word[15:0]};
            SZ_W:    rdata = {{32{word[31]}}, word[31:0]};
            SZ_BU:   rdata = {56'b0, word[7:0]};
            SZ_HU:   rdata = {48'b0, word[15:0]};
            SZ_WU:   rdata = {32'b0, word[31:0]};
            SZ_D:    rdata = word;
            default: rdata = word;
        endcase
    end

    // store merge, only the low two size bits matter
    always_comb begin
        case (size[1:0])
            SZ_B[1:0]: size_mask = 64'h0000_0000_0000_00ff;
            SZ_H[1:0]: size_mask = 64'h0000_0000_0000_ffff;
            SZ_W[1:0]: size_mask = 64'h0000_0000_ffff_ffff;
            default:   size_mask = '1;
        endcase
    end

    assign lane_mask = LINE_W'(size_mask) << shift;
    assign lane_data = LINE_W'(wdata & size_mask) << shift;
    assign line_out  = (hit_line & ~lane_mask) | lane_data;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[set][victim] <= fill_line;
            tag_q[set][victim]  <= tag;
        end else if (store_en) begin
            data_q[set][hit_way] <= line_out;
        end
    end

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < 4; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else if (fill_en) begin
            valid_q[set][victim] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input  wire  clk,
    input  wire  clr_n,
    input  wire  busy,
    input  wire  we,
    input  wire  hit,
    input  wire  fill_done,
    input  wire  write_done,
    input  wire  resp_ready,
    output logic start_read,
    output logic start_write,
    output logic fill_en,
    output logic store_en,
    output logic touch_en,
    output logic resp_valid,
    output logic done
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL,
        MERGE,
        WRITE,
        RESP
    } state_t;

    state_t state;
    state_t state_nx;

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx    = state;
        start_read  = 1'b0;
        start_write = 1'b0;
        fill_en     = 1'b0;
        store_en    = 1'b0;
        touch_en    = 1'b0;
        case (state)
            IDLE: begin
                if (busy) begin
                    state_nx = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    touch_en = 1'b1;
                    state_nx = we ? MERGE : RESP;
                end else begin
                    start_read = 1'b1;
                    state_nx   = FILL;
                end
            end
            FILL: begin
                // fill goes into the victim way, store merge follows if needed
                if (fill_done) begin
                    fill_en  = 1'b1;
                    touch_en = 1'b1;
                    state_nx = we ? MERGE : RESP;
                end
            end
            MERGE: begin
                // the array takes the merged line while the bus port latches it
                store_en    = 1'b1;
                start_write = 1'b1;
                state_nx    = WRITE;
            end
            WRITE: begin
                if (write_done) begin
                    state_nx = RESP;
                end
            end
            RESP: begin
                if (resp_ready) begin
                    state_nx = IDLE;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    assign resp_valid = (state == RESP);
    assign done       = resp_valid && resp_ready;

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] dword_t;
    typedef logic [2:0]  mem_size_t;
    typedef logic [1:0]  way_t;
    typedef logic [2:0]  plru_t;

    // access size codes, signed forms extend the sign bit on load
    localparam mem_size_t SZ_B  = 3'd0;
    localparam mem_size_t SZ_H  = 3'd1;
    localparam mem_size_t SZ_W  = 3'd2;
    localparam mem_size_t SZ_D  = 3'd3;
    localparam mem_size_t SZ_BU = 3'd4;
    localparam mem_size_t SZ_HU = 3'd5;
    localparam mem_size_t SZ_WU = 3'd6;

    localparam int DEF_SETS       = 4;
    localparam int DEF_LINE_BYTES = 16;

    typedef struct packed {
        addr_t     addr;
        mem_size_t size;
        logic      we;
        dword_t    wdata;
    } cache_req_t;

    // we is echoed back so stores and loads can be told apart
    typedef struct packed {
        dword_t rdata;
        logic   we;
    } cache_resp_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int SETS       = DEF_SETS,
    parameter int LINE_BYTES = DEF_LINE_BYTES,
    localparam int SET_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_BYTES),
    localparam int TAG_W     = $bits(addr_t) - SET_W - OFF_W,
    localparam int LINE_W    = LINE_BYTES * 8
) (
    input  wire               clk,
    input  wire               clr_n,
    input  wire cache_req_t   req,
    input  wire               req_valid,
    output logic              req_ready,
    output cache_resp_t       resp,
    output logic              resp_valid,
    input  wire               resp_ready,
    output bus_req_t          bus_req,
    output logic [LINE_W-1:0] bus_wdata,
    output logic              bus_valid,
    input  wire               bus_ready,
    input  wire [LINE_W-1:0]  bus_rdata,
    input  wire               bus_rvalid
);

    cache_req_t        held;
    logic              busy;
    logic              done;
    logic [TAG_W-1:0]  tag;
    logic [SET_W-1:0]  set;
    logic [OFF_W-1:0]  offset;
    logic              hit;
    way_t              hit_way;
    way_t              victim;
    way_t              touch_way;
    dword_t            rdata;
    logic [LINE_W-1:0] line_out;
    logic [LINE_W-1:0] fill_line;
    logic              fill_done;
    logic              write_done;
    logic              start_read;
    logic              start_write;
    logic              fill_en;
    logic              store_en;
    logic              touch_en;

    // a fill touches the victim, a hit its own way
    assign touch_way = hit ? hit_way : victim;
    assign resp      = '{rdata: rdata, we: held.we};

    req_stage #(.SETS(SETS), .LINE_BYTES(LINE_BYTES)) u_req_stage (
        .clk(clk), .clr_n(clr_n), .req(req), .req_valid(req_valid),
        .req_ready(req_ready), .done(done), .held(held), .busy(busy),
        .tag(tag), .set(set), .offset(offset)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .clr_n(clr_n), .busy(busy), .we(held.we), .hit(hit),
        .fill_done(fill_done), .write_done(write_done), .resp_ready(resp_ready),
        .start_read(start_read), .start_write(start_write), .fill_en(fill_en),
        .store_en(store_en), .touch_en(touch_en), .resp_valid(resp_valid), .done(done)
    );

    dcache_array #(.SETS(SETS), .LINE_BYTES(LINE_BYTES)) u_array (
        .clk(clk), .clr_n(clr_n), .tag(tag), .set(set), .offset(offset),
        .size(held.size), .wdata(held.wdata), .victim(victim), .fill_en(fill_en),
        .store_en(store_en), .fill_line(fill_line), .hit(hit), .hit_way(hit_way),
        .rdata(rdata), .line_out(line_out)
    );

    plru_tree #(.SETS(SETS)) u_plru (
        .clk(clk), .clr_n(clr_n), .set(set), .touch_en(touch_en),
        .touch_way(touch_way), .victim(victim)
    );

    bus_port #(.LINE_BYTES(LINE_BYTES)) u_bus_port (
        .clk(clk), .clr_n(clr_n), .line_addr(held.addr), .start_read(start_read),
        .start_write(start_write), .wline(line_out), .bus_req(bus_req),
        .bus_wdata(bus_wdata), .bus_valid(bus_valid), .bus_ready(bus_ready),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid), .fill_line(fill_line),
        .fill_done(fill_done), .write_done(write_done)
    );

endmodule

`default_nettype wire

// ==== hdl/plru_tree.sv ====
`default_nettype none

module plru_tree import dcache_pkg::*; #(
    parameter int SETS   = DEF_SETS,
    localparam int SET_W = $clog2(SETS)
) (
    input  wire             clk,
    input  wire             clr_n,
    input  wire [SET_W-1:0] set,
    input  wire             touch_en,
    input  wire way_t       touch_way,
    output way_t            victim
);

    plru_t tree_q [SETS];
    plru_t cur;

    assign cur = tree_q[set];

    // bit 2 picks the half, bit 1 or bit 0 the way inside it
    assign victim = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_en) begin
            // point away from the touched way
            tree_q[set][2] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[set][0] <= ~touch_way[0];
            end else begin
                tree_q[set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/req_stage.sv ====
`default_nettype none

module req_stage import dcache_pkg::*; #(
    parameter int SETS       = DEF_SETS,
    parameter int LINE_BYTES = DEF_LINE_BYTES,
    localparam int SET_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_BYTES),
    localparam int TAG_W     = $bits(addr_t) - SET_W - OFF_W
) (
    input  wire              clk,
    input  wire              clr_n,
    input  wire cache_req_t  req,
    input  wire              req_valid,
    output logic             req_ready,
    input  wire              done,
    output cache_req_t       held,
    output logic             busy,
    output logic [TAG_W-1:0] tag,
    output logic [SET_W-1:0] set,
    output logic [OFF_W-1:0] offset
);

    // one request in flight, so the stage stays closed until done
    assign req_ready = !busy;

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            held <= req;
        end
    end

    // address split: | tag | set | offset |
    assign offset = held.addr[OFF_W-1:0];
    assign set    = held.addr[OFF_W +: SET_W];
    assign tag    = held.addr[$bits(addr_t)-1 -: TAG_W];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -Mdir obj_dir -f verilog.f
./obj_dir/Vtb_dcache > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1

// ==== test/clk_gen.sv ====
`default_nettype none

module clk_gen #(
    parameter int HALF         = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic clr_n
);

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    initial begin
        clr_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        clr_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`default_nettype none

module mem_model import dcache_pkg::*; #(
    parameter int LINE_BYTES = DEF_LINE_BYTES,
    parameter int MEM_AW     = 12,
    localparam int LINE_W    = LINE_BYTES * 8
) (
    input  wire               clk,
    input  wire bus_req_t     bus_req,
    input  wire [LINE_W-1:0]  bus_wdata,
    input  wire               bus_valid,
    output logic              bus_ready,
    output logic [LINE_W-1:0] bus_rdata,
    output logic              bus_rvalid,
    output int                reads,
    output int                writes,
    output logic [LINE_W-1:0] last_wline
);

    logic [7:0] mem [2**MEM_AW];
    addr_t      rd_addr;
    // cycles left before the fill strobe, negative while no read is pending
    int         rd_delay;

    initial begin
        for (int a = 0; a < 2**MEM_AW; a++) begin
            mem[MEM_AW'(a)] = 8'(a * 7 + 3);
        end
        bus_ready  = 1'b0;
        bus_rdata  = '0;
        bus_rvalid = 1'b0;
        reads      = 0;
        writes     = 0;
        last_wline = '0;
        rd_addr    = '0;
        rd_delay   = -1;
    end

    always @(posedge clk) begin
        addr_t a;
        bus_ready  <= ($urandom % 3) != 0;
        bus_rvalid <= 1'b0;
        if (bus_valid && bus_ready) begin
            if (bus_req.we) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    a = bus_req.addr + addr_t'(b);
                    mem[a[MEM_AW-1:0]] <= bus_wdata[b*8 +: 8];
                end
                writes     <= writes + 1;
                last_wline <= bus_wdata;
            end else begin
                reads    <= reads + 1;
                rd_addr  <= bus_req.addr;
                rd_delay <= int'($urandom % 4);
            end
        end else if (rd_delay == 0) begin
            // line goes out as a one-cycle strobe
            for (int b = 0; b < LINE_BYTES; b++) begin
                a = rd_addr + addr_t'(b);
                bus_rdata[b*8 +: 8] <= mem[a[MEM_AW-1:0]];
            end
            bus_rvalid <= 1'b1;
            rd_delay   <= -1;
        end else if (rd_delay > 0) begin
            rd_delay <= rd_delay - 1;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int SETS       = DEF_SETS;
    localparam int LINE_BYTES = DEF_LINE_BYTES;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int MEM_AW     = 12;
    localparam int TIMEOUT    = 200;
    localparam int NROWS      = 27;

    typedef struct packed {
        addr_t     addr;
        mem_size_t size;
        logic      we;
        dword_t    wdata;
        logic      rd;
    } row_t;

    logic              clk;
    logic              clr_n;
    cache_req_t        req;
    logic              req_valid;
    logic              req_ready;
    cache_resp_t       resp;
    logic              resp_valid;
    logic              resp_ready;
    bus_req_t          bus_req;
    logic [LINE_W-1:0] bus_wdata;
    logic              bus_valid;
    logic              bus_ready;
    logic [LINE_W-1:0] bus_rdata;
    logic              bus_rvalid;
    int                reads;
    int                writes;
    logic [LINE_W-1:0] last_wline;
    addr_t             bus_addr;

    logic [7:0] ref_mem [2**MEM_AW];
    int         checks;
    int         errors;
    int         nresp = 0;
    int         cur_row;
    bit         timed_out;

    // addr, size, we, wdata, expected line reads
    row_t rows [NROWS] = '{
        // one miss in set 1 and then hits with every size code
        '{32'h010, SZ_D,  1'b0, 64'h0, 1'b1},
        '{32'h018, SZ_W,  1'b0, 64'h0, 1'b0},
        '{32'h01c, SZ_WU, 1'b0, 64'h0, 1'b0},
        '{32'h012, SZ_H,  1'b0, 64'h0, 1'b0},
        '{32'h016, SZ_HU, 1'b0, 64'h0, 1'b0},
        '{32'h01f, SZ_B,  1'b0, 64'h0, 1'b0},
        '{32'h011, SZ_BU, 1'b0, 64'h0, 1'b0},
        // store hit and read back
        '{32'h014, SZ_W,  1'b1, 64'h5555_aaaa_8bad_f00d, 1'b0},
        '{32'h014, SZ_W,  1'b0, 64'h0, 1'b0},
        '{32'h010, SZ_D,  1'b0, 64'h0, 1'b0},
        // write-allocate into set 2
        '{32'h02a, SZ_H,  1'b1, 64'h1234_5678_9abc_c0de, 1'b1},
        '{32'h028, SZ_D,  1'b0, 64'h0, 1'b0},
        '{32'h02f, SZ_B,  1'b1, 64'hffff_ffff_ffff_ff80, 1'b0},
        '{32'h02f, SZ_BU, 1'b0, 64'h0, 1'b0},
        '{32'h020, SZ_D,  1'b1, 64'h0123_4567_89ab_cdef, 1'b0},
        '{32'h020, SZ_D,  1'b0, 64'h0, 1'b0},
        // tags A to E in set 0 where E takes the way of A
        '{32'h000, SZ_W,  1'b0, 64'h0, 1'b1},
        '{32'h040, SZ_W,  1'b0, 64'h0, 1'b1},
        '{32'h080, SZ_H,  1'b0, 64'h0, 1'b1},
        '{32'h0c0, SZ_B,  1'b0, 64'h0, 1'b1},
        '{32'h100, SZ_D,  1'b0, 64'h0, 1'b1},
        '{32'h048, SZ_WU, 1'b0, 64'h0, 1'b0},
        '{32'h004, SZ_W,  1'b0, 64'h0, 1'b1},
        '{32'h0c8, SZ_D,  1'b0, 64'h0, 1'b0},
        '{32'h108, SZ_W,  1'b0, 64'h0, 1'b0},
        // store miss in set 3
        '{32'h03c, SZ_W,  1'b1, 64'hdead_beef_cafe_0042, 1'b1},
        '{32'h038, SZ_D,  1'b0, 64'h0, 1'b0}
    };

    clk_gen u_clk (.clk(clk), .clr_n(clr_n));

    mem_model #(.LINE_BYTES(LINE_BYTES), .MEM_AW(MEM_AW)) u_mem (
        .clk(clk), .bus_req(bus_req), .bus_wdata(bus_wdata), .bus_valid(bus_valid),
        .bus_ready(bus_ready), .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid),
        .reads(reads), .writes(writes), .last_wline(last_wline)
    );

    dcache_top #(.SETS(SETS), .LINE_BYTES(LINE_BYTES)) u_dut (
        .clk(clk), .clr_n(clr_n), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready), .bus_req(bus_req),
        .bus_wdata(bus_wdata), .bus_valid(bus_valid), .bus_ready(bus_ready),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid)
    );

    // line address of the last request the bus accepted
    always @(posedge clk) begin
        if (bus_valid && bus_ready) begin
            bus_addr <= bus_req.addr;
        end
    end

    // counts every response transfer including one that no row waits for
    always @(posedge clk) begin
        if (resp_valid && resp_ready) begin
            nresp <= nresp + 1;
        end
    end

    function automatic dword_t load_ref(addr_t addr, mem_size_t size);
        int     nbytes;
        addr_t  a;
        dword_t val;
        nbytes = 1 << size[1:0];
        val    = '0;
        for (int b = 0; b < nbytes; b++) begin
            a = addr + addr_t'(b);
            val[b*8 +: 8] = ref_mem[a[MEM_AW-1:0]];
        end
        // codes 0 to 3 copy the top bit of the access upwards
        if (!size[2] && val[nbytes*8-1]) begin
            val = val | (~64'h0 << (nbytes * 8));
        end
        return val;
    endfunction

    function automatic void store_ref(addr_t addr, mem_size_t size, dword_t wdata);
        int    nbytes;
        addr_t a;
        nbytes = 1 << size[1:0];
        for (int b = 0; b < nbytes; b++) begin
            a = addr + addr_t'(b);
            ref_mem[a[MEM_AW-1:0]] = wdata[b*8 +: 8];
        end
    endfunction

    function automatic logic [LINE_W-1:0] line_ref(addr_t addr);
        logic [LINE_W-1:0] line;
        addr_t             a;
        for (int b = 0; b < LINE_BYTES; b++) begin
            a = (addr & ~addr_t'(LINE_BYTES - 1)) + addr_t'(b);
            line[b*8 +: 8] = ref_mem[a[MEM_AW-1:0]];
        end
        return line;
    endfunction

    task automatic expect_equal(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                                input string what);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: row %0d %s is %h, expected %h",
                     $time, cur_row, what, got, exp);
            errors++;
        end
    endtask

    task automatic run_row(input int i);
        row_t        r;
        cache_resp_t got;
        int          reads0;
        int          writes0;
        int          errors0;
        int          cyc;
        bit          seen;
        r       = rows[i];
        reads0  = reads;
        writes0 = writes;
        errors0 = errors;
        got     = '0;
        req       <= '{addr: r.addr, size: r.size, we: r.we, wdata: r.wdata};
        req_valid <= 1'b1;
        seen = 1'b0;
        for (cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
            @(posedge clk);
            seen = req_ready;
        end
        req_valid <= 1'b0;
        if (!seen) begin
            $display("row %0d: request not accepted within %0d cycles", i, TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        seen = 1'b0;
        for (cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
            // random stalls on the response side
            resp_ready <= ($urandom % 4) != 0;
            @(posedge clk);
            seen = resp_valid && resp_ready;
            got  = resp;
        end
        if (!seen) begin
            $display("row %0d: no response within %0d cycles", i, TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        expect_equal(LINE_W'(got.we), LINE_W'(r.we), "response we");
        expect_equal(LINE_W'(reads - reads0), LINE_W'(r.rd), "bus reads");
        if (r.we || r.rd) begin
            expect_equal(LINE_W'(bus_addr), LINE_W'(r.addr & ~addr_t'(LINE_BYTES - 1)),
                         "bus line address");
        end
        if (r.we) begin
            store_ref(r.addr, r.size, r.wdata);
            expect_equal(LINE_W'(writes - writes0), LINE_W'(1), "bus writes");
            expect_equal(last_wline, line_ref(r.addr), "written line");
        end else begin
            expect_equal(LINE_W'(writes - writes0), '0, "bus writes");
            expect_equal(LINE_W'(got.rdata), LINE_W'(load_ref(r.addr, r.size)), "load data");
        end
        $display("row %0d %s addr %h size %0d: %s", i, r.we ? "store" : "load",
                 r.addr, r.size, (errors == errors0) ? "ok" : "FAILED");
    endtask

    initial begin
        int cyc;
        void'($urandom(19));
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        checks     = 0;
        errors     = 0;
        cur_row    = -1;
        timed_out  = 1'b0;
        for (int a = 0; a < 2**MEM_AW; a++) begin
            ref_mem[MEM_AW'(a)] = 8'(a * 7 + 3);
        end
        for (cyc = 0; cyc < TIMEOUT && clr_n !== 1'b1; cyc++) begin
            @(posedge clk);
        end
        if (clr_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end else begin
            expect_equal(LINE_W'(req_ready), LINE_W'(1), "req_ready after reset");
            expect_equal(LINE_W'(bus_valid), '0, "bus_valid after reset");
            $display("reset state: %s", (errors == 0) ? "ok" : "FAILED");
        end
        for (int i = 0; i < NROWS && !timed_out; i++) begin
            cur_row = i;
            run_row(i);
        end
        if (!timed_out) begin
            // a lost or repeated request shows up as a wrong count or a late response
            cur_row = NROWS;
            repeat (4) begin
                @(posedge clk);
                expect_equal(LINE_W'(resp_valid), '0, "resp_valid when idle");
            end
            expect_equal(LINE_W'(nresp), LINE_W'(NROWS), "response count");
        end
        $display("%0d checks, %0d failed, %0d responses for %0d requests",
                 checks, errors, nresp, NROWS);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/dcache_pkg.sv
hdl/req_stage.sv
hdl/dcache_ctrl.sv
hdl/dcache_array.sv
hdl/plru_tree.sv
hdl/bus_port.sv
hdl/dcache_top.sv
test/clk_gen.sv
test/mem_model.sv
test/tb_dcache.sv
